/* rtl/regs_pkg.sv */
// Register block types: register and pair selectors, command kinds and pipeline structs
`default_nettype none

package regs_pkg;

	typedef enum logic [3:0] {
		REG_A   = 4'd0,
		REG_B   = 4'd1,
		REG_C   = 4'd2,
		REG_D   = 4'd3,
		REG_E   = 4'd4,
		REG_H   = 4'd5,
		REG_L   = 4'd6,
		REG_Z   = 4'd7,
		REG_W   = 4'd8,
		REG_IR  = 4'd9,
		REG_IMM = 4'd10		// Immediate byte, source only
	} reg_sel_e;

	typedef enum logic [2:0] {
		PAIR_BC = 3'd0,
		PAIR_DE = 3'd1,
		PAIR_HL = 3'd2,
		PAIR_WZ = 3'd3,
		PAIR_SP = 3'd4,
		PAIR_PC = 3'd5
	} pair_sel_e;

	typedef enum logic [2:0] {
		CMD_NOP   = 3'd0,
		CMD_LD8   = 3'd1,
		CMD_LD16  = 3'd2,
		CMD_INC16 = 3'd3,
		CMD_DEC16 = 3'd4,
		CMD_FETCH = 3'd5,
		CMD_MEMRD = 3'd6
	} cmd_kind_e;

	// Output address selection
	localparam logic [1:0] ADDR_NONE = 2'd0;	// Address bus idle, reads as zero
	localparam logic [1:0] ADDR_NEW  = 2'd1;	// Pair value after the IDU
	localparam logic [1:0] ADDR_OLD  = 2'd2;	// Pair value before the command

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} byte_pair_t;

	typedef union packed {
		logic [15:0] word;
		byte_pair_t  b;
	} reg_pair_u;

	typedef struct packed {
		cmd_kind_e kind;
		reg_sel_e  dst;
		reg_sel_e  src;
		pair_sel_e pair;
		reg_pair_u imm;
	} cmd_t;

	typedef struct packed {
		logic       byte_we;
		reg_sel_e   byte_dst;
		reg_sel_e   byte_src;
		logic       pair_we;
		pair_sel_e  pair_dst;	// Also the pair read for IDU and address
		logic       idu_inc;
		logic       idu_dec;
		logic       pc_inc;
		logic [1:0] addr_sel;
		reg_pair_u  imm;
	} ctl_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
	} res_t;

endpackage

`default_nettype wire

/* rtl/cmd_decode.sv */
// Command decoder: maps each register-transfer command to registered control signals
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            cmd_valid,
	input  regs_pkg::cmd_t  cmd,
	output logic            ctl_valid,
	output regs_pkg::ctl_t  ctl
);

	regs_pkg::ctl_t ctl_d;
	logic           valid_d;

	always_comb begin
		ctl_d          = '0;
		ctl_d.byte_dst = cmd.dst;
		ctl_d.byte_src = cmd.src;
		ctl_d.pair_dst = cmd.pair;
		ctl_d.addr_sel = regs_pkg::ADDR_NONE;
		ctl_d.imm      = cmd.imm;
		valid_d        = cmd_valid;

		case (cmd.kind)
			regs_pkg::CMD_LD8: begin
				ctl_d.byte_we = 1'b1;		// Register or immediate copy
			end
			regs_pkg::CMD_LD16: begin
				ctl_d.pair_we  = 1'b1;		// IDU passes imm through
				ctl_d.addr_sel = regs_pkg::ADDR_NEW;
			end
			regs_pkg::CMD_INC16: begin
				ctl_d.pair_we  = 1'b1;
				ctl_d.idu_inc  = 1'b1;
				ctl_d.addr_sel = regs_pkg::ADDR_NEW;
			end
			regs_pkg::CMD_DEC16: begin
				ctl_d.pair_we  = 1'b1;
				ctl_d.idu_dec  = 1'b1;
				ctl_d.addr_sel = regs_pkg::ADDR_NEW;
			end
			regs_pkg::CMD_FETCH: begin
				// Opcode byte into IR, PC out and advanced
				ctl_d.byte_we  = 1'b1;
				ctl_d.byte_dst = regs_pkg::REG_IR;
				ctl_d.byte_src = regs_pkg::REG_IMM;
				ctl_d.pair_dst = regs_pkg::PAIR_PC;
				ctl_d.idu_inc  = 1'b1;
				ctl_d.pc_inc   = 1'b1;
				ctl_d.addr_sel = regs_pkg::ADDR_OLD;
			end
			regs_pkg::CMD_MEMRD: begin
				ctl_d.byte_we  = 1'b1;		// Read byte lands in dst
				ctl_d.byte_src = regs_pkg::REG_IMM;
				ctl_d.addr_sel = regs_pkg::ADDR_OLD;
			end
			default: begin
				valid_d = 1'b0;			// NOP or unknown kind
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctl_valid <= 1'b0;
			ctl       <= '0;
		end else begin
			ctl_valid <= valid_d;
			ctl       <= ctl_d;
		end
	end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// Byte register file: A to L, Z, W and IR with byte and pair read and write ports
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ctl_valid,
	input  regs_pkg::ctl_t      ctl,
	output regs_pkg::reg_pair_u pair_rd,
	input  regs_pkg::reg_pair_u pair_wr,
	output logic [7:0]          wdata
);

	logic [7:0]         regs [0:9];		// Indexed by reg_sel_e
	regs_pkg::reg_sel_e hi_sel;
	regs_pkg::reg_sel_e lo_sel;
	logic               pair_local;		// Pair lives in this file
	logic [7:0]         byte_val;

	// High byte of a pair; REG_IMM marks SP and PC, which live elsewhere
	function automatic regs_pkg::reg_sel_e pair_hi(input regs_pkg::pair_sel_e p);
		case (p)
			regs_pkg::PAIR_BC: return regs_pkg::REG_B;
			regs_pkg::PAIR_DE: return regs_pkg::REG_D;
			regs_pkg::PAIR_HL: return regs_pkg::REG_H;
			regs_pkg::PAIR_WZ: return regs_pkg::REG_W;
			default:           return regs_pkg::REG_IMM;
		endcase
	endfunction

	function automatic regs_pkg::reg_sel_e pair_lo(input regs_pkg::pair_sel_e p);
		case (p)
			regs_pkg::PAIR_BC: return regs_pkg::REG_C;
			regs_pkg::PAIR_DE: return regs_pkg::REG_E;
			regs_pkg::PAIR_HL: return regs_pkg::REG_L;
			regs_pkg::PAIR_WZ: return regs_pkg::REG_Z;
			default:           return regs_pkg::REG_IMM;
		endcase
	endfunction

	always_comb begin
		hi_sel     = pair_hi(ctl.pair_dst);
		lo_sel     = pair_lo(ctl.pair_dst);
		pair_local = (hi_sel != regs_pkg::REG_IMM);

		pair_rd.word = 16'h0000;			// SP and PC read as zero here
		if (pair_local) begin
			pair_rd.b.hi = regs[hi_sel];
			pair_rd.b.lo = regs[lo_sel];
		end

		if (ctl.byte_src == regs_pkg::REG_IMM)
			byte_val = ctl.imm.b.lo;
		else
			byte_val = regs[ctl.byte_src];
	end

	// Byte commands report the byte, pair commands the new low byte
	assign wdata = ctl.byte_we ? byte_val : pair_wr.b.lo;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 10; i++)
				regs[i] <= 8'h00;
		end else if (ctl_valid) begin
			if (ctl.pair_we && pair_local) begin
				regs[hi_sel] <= pair_wr.b.hi;
				regs[lo_sel] <= pair_wr.b.lo;
			end
			if (ctl.byte_we && ctl.byte_dst != regs_pkg::REG_IMM)
				regs[ctl.byte_dst] <= byte_val;
		end
	end

endmodule

`default_nettype wire

/* rtl/pointer_unit.sv */
// Pointer unit: SP and PC, the 16-bit increment/decrement unit and output address select
`timescale 1ns/1ps
`default_nettype none

module pointer_unit #(
	parameter logic [15:0] RESET_PC = 16'h0000,
	parameter logic [15:0] RESET_SP = 16'hFFFE
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ctl_valid,
	input  regs_pkg::ctl_t      ctl,
	input  regs_pkg::reg_pair_u pair_rd,
	output regs_pkg::reg_pair_u pair_wr,
	output logic [15:0]         addr
);

	logic [15:0] sp;
	logic [15:0] pc;
	logic [15:0] cur_pair;		// Selected pair before the command
	logic [15:0] idu_in;
	logic [15:0] idu_out;

	always_comb begin
		case (ctl.pair_dst)
			regs_pkg::PAIR_SP: cur_pair = sp;
			regs_pkg::PAIR_PC: cur_pair = pc;
			default:           cur_pair = pair_rd.word;
		endcase
	end

	// Plain load takes the immediate, inc and dec work on the pair
	assign idu_in = (ctl.idu_inc || ctl.idu_dec) ? cur_pair : ctl.imm.word;

	always_comb begin
		if (ctl.idu_inc)
			idu_out = idu_in + 16'd1;	// Wraps FFFF to 0000
		else if (ctl.idu_dec)
			idu_out = idu_in - 16'd1;
		else
			idu_out = idu_in;
	end

	assign pair_wr.word = idu_out;

	always_comb begin
		case (ctl.addr_sel)
			regs_pkg::ADDR_NEW: addr = idu_out;
			regs_pkg::ADDR_OLD: addr = cur_pair;	// FETCH and MEMRD
			default:            addr = 16'h0000;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sp <= RESET_SP;
			pc <= RESET_PC;
		end else if (ctl_valid) begin
			if (ctl.pair_we && ctl.pair_dst == regs_pkg::PAIR_SP)
				sp <= idu_out;
			// Either an explicit PC load or the fetch advance
			if (ctl.pc_inc || (ctl.pair_we && ctl.pair_dst == regs_pkg::PAIR_PC))
				pc <= idu_out;
		end
	end

endmodule

`default_nettype wire

/* rtl/result_stage.sv */
// Result stage: registers address and byte into a result and strobes it once per command
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           ctl_valid,
	input  logic [15:0]    addr,
	input  logic [7:0]     wdata,
	output logic           res_valid,
	output regs_pkg::res_t res
);

	logic           cap_valid;
	regs_pkg::res_t cap_res;

	// Capture stage, sampled at the end of the storage cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cap_valid <= 1'b0;
		else
			cap_valid <= ctl_valid;
	end

	always_ff @(posedge clk) begin
		if (ctl_valid) begin
			cap_res.addr <= addr;
			cap_res.data <= wdata;
		end
	end

	// Output stage gives the fixed three-cycle latency
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= cap_valid;		// One-cycle strobe per result
	end

	always_ff @(posedge clk) begin
		if (cap_valid)
			res <= cap_res;
	end

endmodule

`default_nettype wire

/* rtl/regs_top.sv */
// Register block top: command decoder, register and pointer storage, result stage
`timescale 1ns/1ps
`default_nettype none

module regs_top #(
	parameter logic [15:0] RESET_PC = 16'h0000,
	parameter logic [15:0] RESET_SP = 16'hFFFE
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           cmd_valid,
	input  regs_pkg::cmd_t cmd,
	output logic           res_valid,
	output regs_pkg::res_t res
);

	logic                ctl_valid;
	regs_pkg::ctl_t      ctl;
	regs_pkg::reg_pair_u pair_rd;		// Pair from the byte file
	regs_pkg::reg_pair_u pair_wr;		// IDU result back to the file
	logic [15:0]         addr;
	logic [7:0]          wdata;

	cmd_decode i_cmd_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.ctl_valid (ctl_valid),
		.ctl       (ctl)
	);

	reg_file i_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl_valid (ctl_valid),
		.ctl       (ctl),
		.pair_rd   (pair_rd),
		.pair_wr   (pair_wr),
		.wdata     (wdata)
	);

	pointer_unit #(
		.RESET_PC (RESET_PC),
		.RESET_SP (RESET_SP)
	) i_pointer_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl_valid (ctl_valid),
		.ctl       (ctl),
		.pair_rd   (pair_rd),
		.pair_wr   (pair_wr),
		.addr      (addr)
	);

	result_stage i_result_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl_valid (ctl_valid),
		.addr      (addr),
		.wdata     (wdata),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

`default_nettype wire

/* tests/tb_regs_assert.sv */
// Register block checks: fixed result latency, known result data and idle output in reset
`timescale 1ns/1ps
`default_nettype none

module tb_regs_assert (
	input logic           clk,
	input logic           rst_n,
	input logic           cmd_valid,
	input regs_pkg::cmd_t cmd,
	input logic           res_valid,
	input regs_pkg::res_t res
);

	logic fire;		// Command that must produce a result
	int   fails;		// Assertion failures so far

	initial fails = 0;

	assign fire = cmd_valid && (cmd.kind != regs_pkg::CMD_NOP);

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid == $past(fire, 3))
		else begin
			$error("res_valid does not follow a command by exactly 3 cycles");
			fails++;
		end

	a_res_known: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> !$isunknown(res))
		else begin
			$error("res holds unknown bits while res_valid is high");
			fails++;
		end

	a_reset_idle: assert property (@(posedge clk) !rst_n |-> !res_valid)
		else begin
			$error("res_valid is high during reset");
			fails++;
		end

endmodule

bind regs_top tb_regs_assert i_tb_regs_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.cmd_valid (cmd_valid),
	.cmd       (cmd),
	.res_valid (res_valid),
	.res       (res)
);

`default_nettype wire

/* tests/tb_regs.sv */
// Register block testbench: drives commands from the vector file and checks every result
`timescale 1ns/1ps
`default_nettype none

module tb_regs;

	localparam int          CLK_PERIOD   = 40;
	localparam int          RESET_CYCLES = 10;
	localparam int          LATENCY      = 3;
	localparam int          MAX_VECTORS  = 64;
	localparam logic [15:0] TB_RESET_PC  = 16'h0100;
	localparam logic [15:0] TB_RESET_SP  = 16'hFFFE;

	logic           clk;
	logic           rst_n;
	logic           cmd_valid;
	regs_pkg::cmd_t cmd;
	logic           res_valid;
	regs_pkg::res_t res;

	string          vec_name [MAX_VECTORS];
	regs_pkg::cmd_t vec_cmd  [MAX_VECTORS];
	logic [15:0]    vec_addr [MAX_VECTORS];
	logic [7:0]     vec_data [MAX_VECTORS];
	int             n_vectors;
	int             exp_q [$];		// Vector indices still waiting for a result
	int             errors;
	int             checks;
	integer         seed;

	regs_top #(
		.RESET_PC (TB_RESET_PC),
		.RESET_SP (TB_RESET_SP)
	) i_regs_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.res_valid (res_valid),
		.res       (res)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic read_vectors();
		int             fd;
		int             n;
		string          line;
		string          name;
		logic [15:0]    f_kind;
		logic [15:0]    f_dst;
		logic [15:0]    f_src;
		logic [15:0]    f_pair;
		logic [15:0]    f_imm;
		logic [15:0]    f_addr;
		logic [15:0]    f_data;
		regs_pkg::cmd_t c;
		fd = $fopen("tests/regs_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file tests/regs_vectors.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;		// Blank line or column description
			n = $sscanf(line, "%s %h %h %h %h %h %h %h", name, f_kind, f_dst, f_src,
				f_pair, f_imm, f_addr, f_data);
			if (n != 8) begin
				$display("Malformed line in the vector file: %0s", line);
				errors++;
				continue;
			end
			if (n_vectors == MAX_VECTORS) begin
				$display("Too many vectors in the file, the rest is ignored");
				errors++;
				break;
			end
			c.kind     = regs_pkg::cmd_kind_e'(f_kind[2:0]);
			c.dst      = regs_pkg::reg_sel_e'(f_dst[3:0]);
			c.src      = regs_pkg::reg_sel_e'(f_src[3:0]);
			c.pair     = regs_pkg::pair_sel_e'(f_pair[2:0]);
			c.imm.word = f_imm;
			vec_name[n_vectors] = name;
			vec_cmd[n_vectors]  = c;
			vec_addr[n_vectors] = f_addr;
			vec_data[n_vectors] = f_data[7:0];
			n_vectors++;
		end
		$fclose(fd);
		if (n_vectors == 0) begin
			$display("The vector file holds no commands");
			errors++;
		end
	endtask

	// Idle cycles before the next command
	function automatic int pick_gap();
		logic [31:0] r;
		r = $random(seed);
		if (r[2:0] < 3'd5)
			return 0;		// Mostly back to back
		return int'(r[4:3]) + 1;
	endfunction

	initial begin
		int gap;
		int assert_fails;
		rst_n     = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		n_vectors = 0;
		errors    = 0;
		checks    = 0;
		seed      = 32'h4ea582ce;
		read_vectors();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < n_vectors; i++) begin
			@(posedge clk);
			cmd_valid <= 1'b1;
			cmd       <= vec_cmd[i];
			if (vec_cmd[i].kind != regs_pkg::CMD_NOP)
				exp_q.push_back(i);
			gap = pick_gap();
			repeat (gap) begin
				@(posedge clk);
				cmd_valid <= 1'b0;
				cmd       <= '0;
			end
		end
		@(posedge clk);
		cmd_valid <= 1'b0;
		cmd       <= '0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (LATENCY + 2) @(posedge clk);	// Catch stray results
		assert_fails = i_regs_top.i_tb_regs_assert.fails;
		$display("Results checked: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Results come back in command order
	always @(posedge clk) begin
		int idx;
		if (rst_n && res_valid) begin
			assert (exp_q.size() != 0)
			else begin
				$display("A result arrived with no command outstanding: addr %h data %h",
					res.addr, res.data);
				errors++;
			end
			if (exp_q.size() != 0) begin
				idx = exp_q.pop_front();
				checks++;
				assert (res.addr == vec_addr[idx])
				else begin
					$display("[ERROR] %0s addr: expected %h, actual %h",
						vec_name[idx], vec_addr[idx], res.addr);
					errors++;
				end
				assert (res.data == vec_data[idx])
				else begin
					$display("[ERROR] %0s data: expected %h, actual %h",
						vec_name[idx], vec_data[idx], res.data);
					errors++;
				end
			end
		end
	end

	initial begin
		int limit;
		#1;		// Vector count is known after time zero
		limit = (n_vectors * 8 + RESET_CYCLES) * CLK_PERIOD;
		#(limit);
		$display("Watchdog timeout after %0d ns with %0d results still missing",
			limit, exp_q.size());
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/regs_vectors.txt */
# name kind dst src pair imm addr data, all hex but the name; reset PC 0100, SP FFFE
# kind 0 NOP 1 LD8 2 LD16 3 INC16 4 DEC16 5 FETCH 6 MEMRD; reg A0..L6 Z7 W8 IR9 IMMa
reset_fetch 5 0 0 0 0031 0100 31
reset_sp_inc 3 0 0 4 0000 FFFF FF
sp_wrap_inc 3 0 0 4 0000 0000 00
sp_wrap_dec 4 0 0 4 0000 FFFF FF
ld8_imm_b 1 1 a 0 005A 0000 5A
ld8_b_to_c 1 2 1 0 0000 0000 5A
ld8_c_to_a 1 0 2 0 0000 0000 5A
ld8_imm_e 1 4 a 0 77C3 0000 C3
ld8_e_to_d 1 3 4 0 0000 0000 C3
ld16_bc 2 0 0 0 12FF 12FF FF
inc_bc 3 0 0 0 0000 1300 00
dec_bc 4 0 0 0 0000 12FF FF
ld16_hl 2 0 0 2 FFFF FFFF FF
inc_hl_wrap 3 0 0 2 0000 0000 00
dec_hl_wrap 4 0 0 2 0000 FFFF FF
ld16_sp 2 0 0 4 C000 C000 00
dec_sp 4 0 0 4 0000 BFFF FF
inc_sp 3 0 0 4 0000 C000 00
ld8_from_b 1 0 1 0 0000 0000 12
nop_gap 0 0 0 0 0000 0000 00
fetch_1 5 0 0 0 003E 0101 3E
fetch_2 5 0 0 0 0047 0102 47
fetch_3 5 0 0 0 00A9 0103 A9
ld8_ir_to_z 1 7 9 0 0000 0000 A9
ld16_hl_mem 2 0 0 2 8123 8123 23
memrd_hl 6 0 a 2 00E7 8123 E7
ld8_a_to_w 1 8 0 0 0000 0000 E7
inc_wz 3 0 0 3 0000 E7AA AA
memrd_wz 6 5 a 3 0011 E7AA 11
inc_hl 3 0 0 2 0000 1124 24
ld16_de 2 0 0 1 0000 0000 00
dec_de_wrap 4 0 0 1 0000 FFFF FF
ld8_d_to_l 1 6 3 0 0000 0000 FF
memrd_hl_2 6 2 a 2 0080 11FF 80
dec_bc_2 4 0 0 0 0000 127F 7F
fetch_4 5 0 0 0 0000 0104 00
ld16_pc 2 0 0 5 2000 2000 00
fetch_pc 5 0 0 0 0055 2000 55

/* all.f */
rtl/regs_pkg.sv
rtl/cmd_decode.sv
rtl/reg_file.sv
rtl/pointer_unit.sv
rtl/result_stage.sv
rtl/regs_top.sv
tests/tb_regs_assert.sv
tests/tb_regs.sv

/* run.sh */
#!/bin/bash
# Builds the register block testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_regs -f all.f \
	--Mdir obj_dir -o sim_regs

status=0
./obj_dir/sim_regs > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
